// ==== verilog/dac_pkg.sv ====
//////////////////////////////////////////////////
// shared widths, register map and DAC word layout
// for the AD5601 control subsystem
//////////////////////////////////////////////////

package dac_pkg;

    // bus widths
    localparam int DATA_W      = 16;
    localparam int ADDR_W      = 15;
    localparam int DAC_VALUE_W = 8;

    //////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////

    localparam logic [ADDR_W-1:0] ADDR_VERSION  = 15'd0;
    localparam logic [ADDR_W-1:0] ADDR_DAC_WORD = 15'd1;
    localparam logic [ADDR_W-1:0] ADDR_EN_MMI   = 15'd2;

    // addresses at or above this read as zero
    localparam int NUM_REGS = 3;

    //////////////////////////////////////////////////
    // DAC command word
    //////////////////////////////////////////////////

    // field layout of the 16-bit AD5601 input shift register
    typedef struct packed {
        logic [1:0]             pd_mode;
        logic [DAC_VALUE_W-1:0] value;
        logic [5:0]             reserved;
    } dac_fields_t;

    // raw view is the bus data and the serial frame
    typedef union packed {
        logic [DATA_W-1:0] raw;
        dac_fields_t       fields;
    } dac_word_u;

endpackage

// ==== verilog/mmi_if.sv ====
//////////////////////////////////////////////////
// register bus between the top level and the
// register block, no wait states
//////////////////////////////////////////////////

interface mmi_if;
    import dac_pkg::*;

    // write channel, accepted in the strobe cycle
    logic              wr_stb;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;

    // read channel, rd_valid follows rd_stb by one cycle
    logic              rd_stb;
    logic [ADDR_W-1:0] rd_addr;
    logic              rd_valid;
    logic [DATA_W-1:0] rd_data;

    modport master (
        output wr_stb, wr_addr, wr_data, rd_stb, rd_addr,
        input  rd_valid, rd_data
    );

    modport slave (
        input  wr_stb, wr_addr, wr_data, rd_stb, rd_addr,
        output rd_valid, rd_data
    );

endinterface

// ==== verilog/dac_regs.sv ====
//////////////////////////////////////////////////
// register block holding the DAC command word,
// answers bus reads and merges local value loads
//////////////////////////////////////////////////

module dac_regs #(
    parameter logic [dac_pkg::DATA_W-1:0] MODULE_VERSION = 16'd1,
    parameter logic [dac_pkg::DATA_W-1:0] DAC_DEFAULT    = 16'd100
) (
    input  logic                            clk,
    input  logic                            SET_DEFAULT_ON_RESET,
    input  logic                            en_mmi_ctrl,
    input  logic [dac_pkg::DAC_VALUE_W-1:0] dac_value,
    input  logic                            dac_value_stb,
    mmi_if.slave                            mmi,
    output dac_pkg::dac_word_u              dac_word,
    output logic                            word_changed
);
    import dac_pkg::*;

    logic              bus_load;
    logic              local_load;
    logic [DATA_W-1:0] rd_mux;

    // bus owns the word while mmi control is on, the local strobe otherwise
    assign bus_load   = mmi.wr_stb && (mmi.wr_addr == ADDR_DAC_WORD) && en_mmi_ctrl;
    assign local_load = dac_value_stb && !en_mmi_ctrl;

    //////////////////////////////////////////////////
    // DAC word register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            dac_word.raw <= DAC_DEFAULT;
            word_changed <= 1'b0;
        end else begin
            word_changed <= bus_load || local_load;
            if (bus_load) begin
                dac_word.raw <= mmi.wr_data;
            end else if (local_load) begin
                // mode and reserved bits are kept
                dac_word.fields.value <= dac_value;
            end
        end
    end

    //////////////////////////////////////////////////
    // read path
    //////////////////////////////////////////////////

    always_comb begin
        rd_mux = '0;
        if (mmi.rd_addr < NUM_REGS) begin
            case (mmi.rd_addr)
                ADDR_VERSION:  rd_mux = MODULE_VERSION;
                ADDR_DAC_WORD: rd_mux = dac_word.raw;
                ADDR_EN_MMI:   rd_mux = {{(DATA_W-1){1'b0}}, en_mmi_ctrl};
                default:       rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            mmi.rd_valid <= 1'b0;
        end else begin
            mmi.rd_valid <= mmi.rd_stb;
        end
    end

    // data only matters while rd_valid is high
    always_ff @(posedge clk) begin
        if (mmi.rd_stb) begin
            mmi.rd_data <= rd_mux;
        end
    end

endmodule

// ==== verilog/dac_update_seq.sv ====
//////////////////////////////////////////////////
// decides when a word goes to the DAC, keeps one
// pending update and flags each finished frame
//////////////////////////////////////////////////

module dac_update_seq #(
    parameter bit LOAD_DEFAULT = 1'b1
) (
    input  logic                        clk,
    input  logic                        SET_DEFAULT_ON_RESET,
    input  dac_pkg::dac_word_u          dac_word,
    input  logic                        word_changed,
    input  logic                        busy,
    output logic                        start,
    output logic [dac_pkg::DATA_W-1:0]  tx_word,
    output logic                        dac_reg_updated_stb,
    output logic                        initdone
);
    // start is out but busy not yet high in S_START
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_START = 2'd1;
    localparam logic [1:0] S_BUSY  = 2'd2;

    logic [1:0] state;
    logic       pending;
    logic       load_req;
    logic       frame_done;
    logic       launch;

    assign frame_done = (state == S_BUSY) && !busy;
    assign launch     = ((state == S_IDLE) && (word_changed || load_req)) ||
                        (frame_done && (pending || word_changed));

    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            state               <= S_IDLE;
            start               <= 1'b0;
            pending             <= 1'b0;
            load_req            <= LOAD_DEFAULT;
            dac_reg_updated_stb <= 1'b0;
            initdone            <= 1'b0;
        end else begin
            start               <= launch;
            dac_reg_updated_stb <= frame_done;
            load_req            <= 1'b0;
            if (!LOAD_DEFAULT || frame_done) begin
                initdone <= 1'b1;
            end
            case (state)
                S_IDLE:  if (launch) state <= S_START;
                S_START: begin
                    state   <= S_BUSY;
                    pending <= pending || word_changed;
                end
                S_BUSY: begin
                    if (frame_done) begin
                        pending <= 1'b0;
                        state   <= launch ? S_START : S_IDLE;
                    end else if (word_changed) begin
                        // later changes merge into the same flag
                        pending <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // snapshot of the latest word at launch time
    always_ff @(posedge clk) begin
        if (launch) begin
            tx_word <= dac_word.raw;
        end
    end

endmodule

// ==== verilog/spi_tx.sv ====
//////////////////////////////////////////////////
// serial transmitter for the AD5601, shifts one
// 16-bit word MSB first framed by sync_n
//////////////////////////////////////////////////

module spi_tx #(
    parameter int CLK_DIVIDE = 2
) (
    input  logic                       clk,
    input  logic                       SET_DEFAULT_ON_RESET,
    input  logic                       start,
    input  logic [dac_pkg::DATA_W-1:0] tx_word,
    output logic                       busy,
    output logic                       sclk,
    output logic                       sync_n,
    output logic                       sdin
);
    import dac_pkg::*;

    localparam int DIV_W = (CLK_DIVIDE > 1) ? $clog2(CLK_DIVIDE) : 1;
    localparam int BIT_W = $clog2(DATA_W);

    logic [DIV_W-1:0]  div_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic [DATA_W-1:0] shift_reg;
    logic              half_tick;
    logic              last_bit;

    // one half sclk period every CLK_DIVIDE clocks
    assign half_tick = (div_cnt == DIV_W'(CLK_DIVIDE - 1));
    assign last_bit  = (bit_cnt == BIT_W'(DATA_W - 1));

    // the frame lasts exactly as long as sync_n is low
    assign busy = !sync_n;
    assign sdin = shift_reg[DATA_W-1];

    //////////////////////////////////////////////////
    // frame control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (SET_DEFAULT_ON_RESET) begin
            sync_n  <= 1'b1;
            sclk    <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else if (sync_n) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            if (start) begin
                sync_n <= 1'b0;
            end
        end else if (half_tick) begin
            div_cnt <= '0;
            sclk    <= !sclk;
            // rising edge closes a bit period
            if (!sclk) begin
                if (last_bit) begin
                    sync_n <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // next bit appears on the sclk rising edge
    always_ff @(posedge clk) begin
        if (sync_n && start) begin
            shift_reg <= tx_word;
        end else if (!sync_n && half_tick && !sclk) begin
            shift_reg <= {shift_reg[DATA_W-2:0], 1'b0};
        end
    end

endmodule

// ==== verilog/dac_ctrl_top.sv ====
//////////////////////////////////////////////////
// AD5601 control subsystem top level with plain
// register-bus ports and the DAC serial pins
//////////////////////////////////////////////////

module dac_ctrl_top #(
    parameter logic [dac_pkg::DATA_W-1:0] MODULE_VERSION = 16'd1,
    parameter logic [dac_pkg::DATA_W-1:0] DAC_DEFAULT    = 16'd100,
    parameter bit                         LOAD_DEFAULT   = 1'b1,
    parameter int                         CLK_DIVIDE     = 2
) (
    input  logic                            clk,
    input  logic                            SET_DEFAULT_ON_RESET,
    input  logic                            wr_stb,
    input  logic [dac_pkg::ADDR_W-1:0]      wr_addr,
    input  logic [dac_pkg::DATA_W-1:0]      wr_data,
    input  logic                            rd_stb,
    input  logic [dac_pkg::ADDR_W-1:0]      rd_addr,
    input  logic                            en_mmi_ctrl,
    input  logic [dac_pkg::DAC_VALUE_W-1:0] dac_value,
    input  logic                            dac_value_stb,
    output logic                            rd_valid,
    output logic [dac_pkg::DATA_W-1:0]      rd_data,
    output logic                            sclk,
    output logic                            sync_n,
    output logic                            sdin,
    output logic                            dac_reg_updated_stb,
    output logic                            initdone
);
    import dac_pkg::*;

    dac_word_u         dac_word;
    logic              word_changed;
    logic              start;
    logic              busy;
    logic [DATA_W-1:0] tx_word;

    // register bus from the plain ports
    mmi_if mmi ();

    assign mmi.wr_stb  = wr_stb;
    assign mmi.wr_addr = wr_addr;
    assign mmi.wr_data = wr_data;
    assign mmi.rd_stb  = rd_stb;
    assign mmi.rd_addr = rd_addr;
    assign rd_valid    = mmi.rd_valid;
    assign rd_data     = mmi.rd_data;

    dac_regs #(
        .MODULE_VERSION (MODULE_VERSION),
        .DAC_DEFAULT    (DAC_DEFAULT)
    ) u_regs (
        .clk                  (clk),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .en_mmi_ctrl          (en_mmi_ctrl),
        .dac_value            (dac_value),
        .dac_value_stb        (dac_value_stb),
        .mmi                  (mmi.slave),
        .dac_word             (dac_word),
        .word_changed         (word_changed)
    );

    dac_update_seq #(
        .LOAD_DEFAULT (LOAD_DEFAULT)
    ) u_seq (
        .clk                  (clk),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .dac_word             (dac_word),
        .word_changed         (word_changed),
        .busy                 (busy),
        .start                (start),
        .tx_word              (tx_word),
        .dac_reg_updated_stb  (dac_reg_updated_stb),
        .initdone             (initdone)
    );

    spi_tx #(
        .CLK_DIVIDE (CLK_DIVIDE)
    ) u_spi_tx (
        .clk                  (clk),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .start                (start),
        .tx_word              (tx_word),
        .busy                 (busy),
        .sclk                 (sclk),
        .sync_n               (sync_n),
        .sdin                 (sdin)
    );

endmodule

// ==== sim/clk_gen.sv ====
//////////////////////////////////////////////////
// free-running testbench clock
//////////////////////////////////////////////////

module clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// ==== sim/dac_ctrl_assert.sv ====
//////////////////////////////////////////////////
// protocol assertions bound into the DAC top level
//////////////////////////////////////////////////

module dac_ctrl_assert (
    input logic clk,
    input logic SET_DEFAULT_ON_RESET,
    input logic sclk,
    input logic sync_n,
    input logic dac_reg_updated_stb,
    input logic rd_stb,
    input logic rd_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // number of failed assertions
    int fail_count = 0;

    // sclk idles high outside a frame
    sclk_idle_high: assert property (@(posedge clk) disable iff (SET_DEFAULT_ON_RESET)
        sync_n |-> sclk)
        else begin
            fail_count++;
            $error("sclk low while sync_n is high");
        end

    update_stb_width: assert property (@(posedge clk) disable iff (SET_DEFAULT_ON_RESET)
        dac_reg_updated_stb |=> !dac_reg_updated_stb)
        else begin
            fail_count++;
            $error("dac_reg_updated_stb longer than one cycle");
        end

    // rd_valid exactly one cycle after rd_stb
    read_latency: assert property (@(posedge clk) disable iff (SET_DEFAULT_ON_RESET)
        rd_stb |=> rd_valid)
        else begin
            fail_count++;
            $error("rd_valid missing one cycle after rd_stb");
        end

    read_no_spurious: assert property (@(posedge clk) disable iff (SET_DEFAULT_ON_RESET)
        !rd_stb |=> !rd_valid)
        else begin
            fail_count++;
            $error("rd_valid without a preceding rd_stb");
        end

endmodule

bind dac_ctrl_top dac_ctrl_assert u_assert (.*);

// ==== sim/dac_ctrl_tb.sv ====
//////////////////////////////////////////////////
// directed tests for the AD5601 control subsystem
//////////////////////////////////////////////////

module dac_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] VERSION      = 16'h0102;
    localparam logic [15:0] DEFAULT_WORD = 16'd100;
    localparam int          CLK_DIVIDE   = 2;
    // 16 sclk periods plus the start and done cycles
    localparam int          FRAME_CYCLES = 16 * 2 * CLK_DIVIDE + 4;
    localparam int          NUM_FRAMES   = 6;
    // quiet windows that wait for a frame which must not appear
    localparam int          NUM_QUIET    = 3;
    localparam int          RUN_NS       = ((NUM_FRAMES + NUM_QUIET) * FRAME_CYCLES + 600) * 4;

    logic        clk;
    logic        SET_DEFAULT_ON_RESET;
    logic        wr_stb, rd_stb, en_mmi_ctrl, dac_value_stb;
    logic [14:0] wr_addr, rd_addr;
    logic [15:0] wr_data, rd_data;
    logic [7:0]  dac_value;
    logic        rd_valid, sclk, sync_n, sdin, dac_reg_updated_stb, initdone;

    logic [15:0] frame_bits;
    logic [15:0] frames[$];
    logic [31:0] lfsr_state;
    logic [15:0] model_word;
    int          bit_cnt = 0;
    int          frame_count = 0;
    int          stb_count = 0;
    int          mismatches = 0;
    int          other_errors = 0;

    clk_gen #(.PERIOD_NS(4)) u_clk (.clk(clk));

    dac_ctrl_top #(
        .MODULE_VERSION (VERSION),
        .DAC_DEFAULT    (DEFAULT_WORD),
        .LOAD_DEFAULT   (1'b1),
        .CLK_DIVIDE     (CLK_DIVIDE)
    ) uut (.*);

    //////////////////////////////////////////////////
    // serial monitor
    //////////////////////////////////////////////////

    // the DAC samples sdin on the falling sclk edge
    always @(negedge sclk) begin
        if (sync_n === 1'b0) begin
            frame_bits = {frame_bits[14:0], sdin};
            bit_cnt++;
            if (bit_cnt == 16) begin
                frames.push_back(frame_bits);
                frame_count++;
                bit_cnt = 0;
            end
        end
    end

    always @(negedge sync_n) begin
        bit_cnt = 0;
    end

    always @(posedge clk) begin
        if (dac_reg_updated_stb === 1'b1) begin
            stb_count++;
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        other_errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic bus_write(input logic [14:0] addr, input logic [15:0] data);
        wr_stb  = 1'b1;
        wr_addr = addr;
        wr_data = data;
        next_cycle();
        wr_stb = 1'b0;
    endtask

    task automatic bus_read_check(input logic [14:0] addr, input logic [15:0] exp);
        rd_stb  = 1'b1;
        rd_addr = addr;
        next_cycle();
        rd_stb = 1'b0;
        check("rd_valid", rd_valid, 1);
        check($sformatf("rd_data[%0d]", addr), rd_data, exp);
        next_cycle();
        check("rd_valid", rd_valid, 0);
    endtask

    task automatic local_write(input logic [7:0] value);
        dac_value_stb = 1'b1;
        dac_value     = value;
        next_cycle();
        dac_value_stb = 1'b0;
    endtask

    task automatic wait_updates(input int target);
        int n;
        n = 0;
        while (stb_count < target && n < 3 * FRAME_CYCLES) begin
            next_cycle();
            n++;
        end
        if (stb_count < target) begin
            report_error("dac_reg_updated_stb did not arrive after the frame");
        end
    endtask

    task automatic check_frame(input logic [15:0] exp);
        if (frames.size() == 0) begin
            report_error("expected a serial frame but none was captured");
        end else begin
            check("frame", frames.pop_front(), exp);
        end
    endtask

    task automatic expect_no_frame(input string why);
        int base;
        base = stb_count;
        // long enough for a started frame and its update strobe to show up
        repeat (FRAME_CYCLES + 8) next_cycle();
        check({why, " frames"}, frames.size(), 0);
        check({why, " updates"}, stb_count, base);
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_default();
        check("initdone", initdone, 0);
        wait_updates(1);
        check_frame(DEFAULT_WORD);
        check("initdone", initdone, 1);
        model_word = DEFAULT_WORD;
    endtask

    task automatic test_reg_reads();
        int a;
        en_mmi_ctrl = 1'b1;
        bus_read_check(15'd0, VERSION);
        bus_read_check(15'd1, model_word);
        bus_read_check(15'd2, 16'd1);
        en_mmi_ctrl = 1'b0;
        bus_read_check(15'd2, 16'd0);
        for (a = 3; a <= 6; a++) begin
            bus_read_check(15'(a), 16'd0);
        end
        en_mmi_ctrl = 1'b1;
    endtask

    task automatic test_bus_writes();
        logic [15:0] w;
        int          base;
        w = 16'(rand_bits(16));
        base = stb_count;
        bus_write(15'd1, w);
        model_word = w;
        bus_read_check(15'd1, w);
        wait_updates(base + 1);
        check_frame(w);
        en_mmi_ctrl = 1'b0;
        bus_write(15'd1, ~w);
        bus_read_check(15'd1, model_word);
        expect_no_frame("write with mmi control off");
        en_mmi_ctrl = 1'b1;
        bus_write(15'd0, 16'(rand_bits(16)));
        bus_write(15'd2, 16'(rand_bits(16)));
        expect_no_frame("write to read-only address");
        bus_read_check(15'd0, VERSION);
        bus_read_check(15'd1, model_word);
        bus_read_check(15'd2, 16'd1);
    endtask

    task automatic test_local_updates();
        logic [7:0] v;
        int         base;
        en_mmi_ctrl = 1'b0;
        v = 8'(rand_bits(8));
        base = stb_count;
        local_write(v);
        // mode and reserved fields stay, value sits in bits 13..6
        model_word[13:6] = v;
        wait_updates(base + 1);
        check_frame(model_word);
        bus_read_check(15'd1, model_word);
        en_mmi_ctrl = 1'b1;
        local_write(~v);
        expect_no_frame("local strobe with mmi control on");
        bus_read_check(15'd1, model_word);
    endtask

    task automatic test_back_pressure();
        logic [15:0] first;
        logic [15:0] w;
        int          base;
        int          n;
        base = stb_count;
        first = 16'(rand_bits(16));
        bus_write(15'd1, first);
        n = 0;
        while (sync_n !== 1'b0 && n < 10) begin
            next_cycle();
            n++;
        end
        if (sync_n !== 1'b0) begin
            report_error("no frame started after a bus write");
        end
        // several writes land inside the running frame
        repeat (3) begin
            w = 16'(rand_bits(16));
            bus_write(15'd1, w);
            repeat (4) next_cycle();
        end
        model_word = w;
        wait_updates(base + 2);
        repeat (FRAME_CYCLES) next_cycle();
        check("frames after burst", frames.size(), 2);
        check_frame(first);
        check_frame(w);
        check("updates after burst", stb_count, base + 2);
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        SET_DEFAULT_ON_RESET = 1'b1;
        wr_stb        = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        rd_stb        = 1'b0;
        rd_addr       = '0;
        en_mmi_ctrl   = 1'b1;
        dac_value     = '0;
        dac_value_stb = 1'b0;
        lfsr_state    = 32'ha250_0a9d;
        repeat (2) @(posedge clk);
        #1;
        SET_DEFAULT_ON_RESET = 1'b0;
        test_reset_default();
        test_reg_reads();
        test_bus_writes();
        test_local_updates();
        test_back_pressure();
        check("frames vs updates", frame_count, stb_count);
        $display("mismatches %0d, other errors %0d, assertion failures %0d",
                 mismatches, other_errors, uut.u_assert.fail_count);
        if (mismatches + other_errors + uut.u_assert.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(RUN_NS);
        $display("Timeout: the run did not finish within %0d ns", RUN_NS);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== files.f ====
verilog/dac_pkg.sv
verilog/mmi_if.sv
verilog/dac_regs.sv
verilog/dac_update_seq.sv
verilog/spi_tx.sv
verilog/dac_ctrl_top.sv
sim/clk_gen.sv
sim/dac_ctrl_assert.sv
sim/dac_ctrl_tb.sv
